// ==== line_buffer_params.svh ====
`ifndef LINE_BUFFER_PARAMS_SVH
`define LINE_BUFFER_PARAMS_SVH

// width, height, row and col counters
`define LB_W_SIZE      8
// tiled channel count
`define LB_W_CHANNEL   6

// one feature-map word
`define LB_IFM_DW      32

// feature-map RAM
`define LB_FM_AW       12
`define LB_FM_DEPTH    4096

// one row of width x channels elements
`define LB_ROW_AW      11
`define LB_ROW_DEPTH   2048

// axi read data carries one word per beat
`define LB_AXI_DW      `LB_IFM_DW

`endif

// ==== lb_data_pkg.sv ====
`include "line_buffer_params.svh"

package lb_data_pkg;

    // one feature-map element
    typedef logic [`LB_IFM_DW-1:0] ifm_word_t;

    // addresses
    typedef logic [`LB_FM_AW-1:0]  fm_addr_t;
    typedef logic [`LB_ROW_AW-1:0] row_addr_t;

    // geometry
    typedef logic [`LB_W_SIZE-1:0]    size_t;
    typedef logic [`LB_W_CHANNEL-1:0] chn_t;
    // width x channels
    typedef logic [`LB_W_SIZE+`LB_W_CHANNEL-1:0] stride_t;

endpackage

// ==== lb_ctrl_pkg.sv ====
package lb_ctrl_pkg;

    // role of a row buffer in the 3-row window
    typedef enum logic [1:0] {
        ROLE_ABV = 2'd0,
        ROLE_CUR = 2'd1,
        ROLE_BEL = 2'd2
    } row_role_e;

    // row-0 prefill
    typedef enum logic [1:0] {
        PF_IDLE = 2'd0,
        PF_RUN  = 2'd1,
        PF_DONE = 2'd2
    } prefill_state_e;

endpackage

// ==== dpram.sv ====
`timescale 1ns/10ps

module dpram #(
    parameter int DEPTH = 1024,
    parameter int AW    = 10,
    parameter int DW    = 32
) (
    input  logic          clk,
    input  logic          wr_en,
    input  logic [AW-1:0] wr_addr,
    input  logic [DW-1:0] wr_data,
    input  logic          rd_en,
    input  logic [AW-1:0] rd_addr,
    output logic [DW-1:0] rd_data
);

    logic [DW-1:0] mem [DEPTH];

    // write port
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, holds while rd_en low
    // same-address collision returns the old word
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// ==== ifm_loader.sv ====
`timescale 1ns/10ps

module ifm_loader (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  load_ifm,
    input  lb_data_pkg::ifm_word_t axi_data,
    input  logic                  axi_vld,
    output logic                  fm_wr_en,
    output lb_data_pkg::fm_addr_t  fm_wr_addr,
    output lb_data_pkg::ifm_word_t fm_wr_data
);

    logic load_d;
    logic load_start;

    // new image begins on rise of the load level
    assign load_start = load_ifm & ~load_d;

    // --------------------
    // write strobe and address
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            load_d     <= 1'b0;
            fm_wr_en   <= 1'b0;
            fm_wr_addr <= '0;
        end else begin
            load_d   <= load_ifm;
            // only words seen while loading
            fm_wr_en <= load_ifm & axi_vld;
            // restart at 0, step after each write
            if (load_start) begin
                fm_wr_addr <= '0;
            end else if (fm_wr_en) begin
                fm_wr_addr <= fm_wr_addr + 1'b1;
            end
        end
    end

    // data word lines up with the strobe
    always_ff @(posedge clk) begin
        fm_wr_data <= axi_data;
    end

endmodule

// ==== prefill_ctrl.sv ====
`timescale 1ns/10ps

module prefill_ctrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  csync_run,
    input  logic                  data_run,
    input  lb_data_pkg::stride_t   row_stride,
    output logic                  frame_start,
    output logic                  scan_start,
    output logic                  pf_active,
    output lb_data_pkg::row_addr_t pf_addr,
    output logic                  pf_wr_vld,
    output lb_data_pkg::row_addr_t pf_wr_addr,
    output logic                  csync_done
);

    import lb_data_pkg::*;
    import lb_ctrl_pkg::*;

    prefill_state_e state;
    logic           csync_d;
    logic           data_d;
    logic           armed;
    logic           last_addr;

    // --------------------
    // run edges
    // --------------------
    assign frame_start = csync_run & ~csync_d;
    // only the first data run of a frame, idle gaps inside a row do not count
    assign scan_start  = data_run & ~data_d & armed;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            csync_d <= 1'b0;
            data_d  <= 1'b0;
            armed   <= 1'b0;
        end else begin
            csync_d <= csync_run;
            data_d  <= data_run;
            if (frame_start) begin
                armed <= 1'b1;
            end else if (scan_start) begin
                armed <= 1'b0;
            end
        end
    end

    // --------------------
    // row-0 copy
    // --------------------
    assign last_addr = (stride_t'(pf_addr) == row_stride - 1'b1);
    assign pf_active = (state == PF_RUN);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state   <= PF_IDLE;
            pf_addr <= '0;
        end else if (frame_start) begin
            state   <= PF_RUN;
            pf_addr <= '0;
        end else if (!csync_run || scan_start) begin
            state <= PF_IDLE;
        end else if (state == PF_RUN) begin
            pf_addr <= pf_addr + 1'b1;
            if (last_addr) begin
                state <= PF_DONE;
            end
        end
    end

    // row-buffer write waits for the RAM read
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            pf_wr_vld <= 1'b0;
        end else begin
            pf_wr_vld <= pf_active;
        end
    end

    always_ff @(posedge clk) begin
        pf_wr_addr <= pf_addr;
    end

    assign csync_done = (state == PF_DONE) & csync_run;

endmodule

// ==== window_addr_gen.sv ====
`timescale 1ns/10ps

module window_addr_gen (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  frame_start,
    input  logic                  pf_active,
    input  lb_data_pkg::row_addr_t pf_addr,
    input  logic                  data_run,
    input  lb_data_pkg::size_t     row,
    input  lb_data_pkg::size_t     col,
    input  lb_data_pkg::chn_t      chn,
    input  lb_data_pkg::chn_t      channel,
    input  lb_data_pkg::stride_t   row_stride,
    input  logic                  is_first_row,
    input  logic                  is_last_row,
    input  logic                  is_last_col,
    input  logic                  is_last_chn,
    output logic                  fm_rd_en,
    output lb_data_pkg::fm_addr_t  fm_rd_addr,
    output logic                  row_rd_en,
    output lb_data_pkg::row_addr_t row_rd_addr,
    output lb_data_pkg::row_addr_t row_wr_addr,
    output logic                  beat_vld_d,
    output logic                  first_row_d,
    output logic                  last_row_d,
    output logic                  row_advance_d
);

    import lb_data_pkg::*;

    stride_t   in_row;
    fm_addr_t  row_base;
    fm_addr_t  cur_base;
    fm_addr_t  below_addr;
    fm_addr_t  below_q;
    row_addr_t off_q;
    logic      s1_vld;
    logic      s1_first;
    logic      s1_last;
    logic      s1_end;

    // --------------------
    // addressing
    // --------------------
    // col x channels + chn, channel innermost
    assign in_row     = col * channel + chn;
    // row 0 always starts at address 0
    assign cur_base   = (row == '0) ? '0 : row_base;
    assign below_addr = cur_base + fm_addr_t'(in_row) + fm_addr_t'(row_stride);

    // base steps one stride at each row end
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            row_base <= '0;
        end else if (frame_start) begin
            row_base <= '0;
        end else if (data_run && is_last_col && is_last_chn && !is_last_row) begin
            row_base <= cur_base + fm_addr_t'(row_stride);
        end
    end

    // stage 1 read addresses, write address one stage later
    always_ff @(posedge clk) begin
        off_q       <= row_addr_t'(in_row);
        below_q     <= below_addr;
        row_wr_addr <= off_q;
    end

    // --------------------
    // control pipe
    // --------------------
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            s1_vld        <= 1'b0;
            s1_first      <= 1'b0;
            s1_last       <= 1'b0;
            s1_end        <= 1'b0;
            beat_vld_d    <= 1'b0;
            first_row_d   <= 1'b0;
            last_row_d    <= 1'b0;
            row_advance_d <= 1'b0;
        end else begin
            s1_vld        <= data_run;
            s1_first      <= is_first_row;
            s1_last       <= is_last_row;
            s1_end        <= is_last_col & is_last_chn;
            beat_vld_d    <= s1_vld;
            first_row_d   <= s1_first;
            last_row_d    <= s1_last;
            row_advance_d <= s1_vld & s1_end;
        end
    end

    // no row below the last one, so no feature-map read
    // prefill owns the read port while active
    assign fm_rd_en    = pf_active | (s1_vld & ~s1_last);
    assign fm_rd_addr  = pf_active ? fm_addr_t'(pf_addr) : below_q;
    assign row_rd_en   = s1_vld;
    assign row_rd_addr = off_q;

endmodule

// ==== row_window.sv ====
`timescale 1ns/10ps
`include "line_buffer_params.svh"

module row_window (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  scan_start,
    input  logic                  pf_wr_vld,
    input  lb_data_pkg::row_addr_t pf_wr_addr,
    input  logic                  row_rd_en,
    input  lb_data_pkg::row_addr_t row_rd_addr,
    input  lb_data_pkg::row_addr_t row_wr_addr,
    input  logic                  beat_vld_d,
    input  logic                  first_row_d,
    input  logic                  last_row_d,
    input  logic                  row_advance_d,
    input  lb_data_pkg::ifm_word_t fm_rd_data,
    output lb_data_pkg::ifm_word_t ib_data0,
    output lb_data_pkg::ifm_word_t ib_data1,
    output lb_data_pkg::ifm_word_t ib_data2
);

    import lb_data_pkg::*;
    import lb_ctrl_pkg::*;

    row_role_e role [3];
    ifm_word_t row_dout [3];
    row_addr_t wr_addr [3];
    logic      row_wr_en [3];
    logic      bel_wr;
    ifm_word_t abv_word;
    ifm_word_t cur_word;

    // --------------------
    // role pointers
    // --------------------
    // buffer 0 holds prefilled row 0 at scan start
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            role[0] <= ROLE_CUR;
            role[1] <= ROLE_BEL;
            role[2] <= ROLE_ABV;
        end else if (scan_start) begin
            role[0] <= ROLE_CUR;
            role[1] <= ROLE_BEL;
            role[2] <= ROLE_ABV;
        end else if (row_advance_d) begin
            // cur -> abv, bel -> cur, abv -> bel
            role[0] <= role[2];
            role[1] <= role[0];
            role[2] <= role[1];
        end
    end

    // --------------------
    // row buffers
    // --------------------
    // below word fills the BEL buffer as the row is scanned
    assign bel_wr = beat_vld_d & ~last_row_d;

    for (genvar g = 0; g < 3; g++) begin : g_row
        // prefill lands in buffer 0 only
        assign row_wr_en[g] = (pf_wr_vld && g == 0) || (bel_wr && role[g] == ROLE_BEL);
        assign wr_addr[g]   = (pf_wr_vld && g == 0) ? pf_wr_addr : row_wr_addr;

        dpram #(
            .DEPTH (`LB_ROW_DEPTH),
            .AW    (`LB_ROW_AW),
            .DW    (`LB_IFM_DW)
        ) u_row_buf (
            .clk     (clk),
            .wr_en   (row_wr_en[g]),
            .wr_addr (wr_addr[g]),
            .wr_data (fm_rd_data),
            .rd_en   (row_rd_en),
            .rd_addr (row_rd_addr),
            .rd_data (row_dout[g])
        );
    end

    // --------------------
    // window output
    // --------------------
    always_comb begin
        abv_word = '0;
        cur_word = '0;
        for (int i = 0; i < 3; i++) begin
            if (role[i] == ROLE_ABV) begin
                abv_word = row_dout[i];
            end
            if (role[i] == ROLE_CUR) begin
                cur_word = row_dout[i];
            end
        end
    end

    // zero padding at top and bottom, zero words on idle cycles
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ib_data0 <= '0;
            ib_data1 <= '0;
            ib_data2 <= '0;
        end else begin
            ib_data0 <= (beat_vld_d && !first_row_d) ? abv_word : '0;
            ib_data1 <= beat_vld_d ? cur_word : '0;
            ib_data2 <= (beat_vld_d && !last_row_d) ? fm_rd_data : '0;
        end
    end

endmodule

// ==== line_buffer.sv ====
`timescale 1ns/10ps
`include "line_buffer_params.svh"

module line_buffer (
    input  logic                   clk,
    input  logic                   rstn,
    input  lb_data_pkg::chn_t       q_channel,
    input  lb_data_pkg::stride_t    q_row_stride,
    input  logic                   q_load_ifm,
    input  logic [`LB_AXI_DW-1:0]  read_data,
    input  logic                   read_data_vld,
    input  logic                   c_ctrl_data_run,
    input  logic                   c_ctrl_csync_run,
    input  lb_data_pkg::size_t      c_row,
    input  lb_data_pkg::size_t      c_col,
    input  lb_data_pkg::chn_t       c_chn,
    input  logic                   c_is_first_row,
    input  logic                   c_is_last_row,
    input  logic                   c_is_last_col,
    input  logic                   c_is_last_chn,
    output logic                   bm_csync_done,
    output lb_data_pkg::ifm_word_t  ib_data0,
    output lb_data_pkg::ifm_word_t  ib_data1,
    output lb_data_pkg::ifm_word_t  ib_data2
);

    import lb_data_pkg::*;

    // feature-map RAM ports
    logic      fm_wr_en;
    fm_addr_t  fm_wr_addr;
    ifm_word_t fm_wr_data;
    logic      fm_rd_en;
    fm_addr_t  fm_rd_addr;
    ifm_word_t fm_rd_data;
    // prefill
    logic      frame_start;
    logic      scan_start;
    logic      pf_active;
    row_addr_t pf_addr;
    logic      pf_wr_vld;
    row_addr_t pf_wr_addr;
    // scan pipe toward the row buffers
    logic      row_rd_en;
    row_addr_t row_rd_addr;
    row_addr_t row_wr_addr;
    logic      beat_vld_d;
    logic      first_row_d;
    logic      last_row_d;
    logic      row_advance_d;

    // --------------------
    // load
    // --------------------
    ifm_loader u_loader (
        .clk        (clk),
        .rstn       (rstn),
        .load_ifm   (q_load_ifm),
        .axi_data   (read_data),
        .axi_vld    (read_data_vld),
        .fm_wr_en   (fm_wr_en),
        .fm_wr_addr (fm_wr_addr),
        .fm_wr_data (fm_wr_data)
    );

    dpram #(
        .DEPTH (`LB_FM_DEPTH),
        .AW    (`LB_FM_AW),
        .DW    (`LB_IFM_DW)
    ) u_fm_ram (
        .clk     (clk),
        .wr_en   (fm_wr_en),
        .wr_addr (fm_wr_addr),
        .wr_data (fm_wr_data),
        .rd_en   (fm_rd_en),
        .rd_addr (fm_rd_addr),
        .rd_data (fm_rd_data)
    );

    // --------------------
    // prefill and scan
    // --------------------
    prefill_ctrl u_prefill (
        .clk         (clk),
        .rstn        (rstn),
        .csync_run   (c_ctrl_csync_run),
        .data_run    (c_ctrl_data_run),
        .row_stride  (q_row_stride),
        .frame_start (frame_start),
        .scan_start  (scan_start),
        .pf_active   (pf_active),
        .pf_addr     (pf_addr),
        .pf_wr_vld   (pf_wr_vld),
        .pf_wr_addr  (pf_wr_addr),
        .csync_done  (bm_csync_done)
    );

    window_addr_gen u_addr (
        .clk           (clk),
        .rstn          (rstn),
        .frame_start   (frame_start),
        .pf_active     (pf_active),
        .pf_addr       (pf_addr),
        .data_run      (c_ctrl_data_run),
        .row           (c_row),
        .col           (c_col),
        .chn           (c_chn),
        .channel       (q_channel),
        .row_stride    (q_row_stride),
        .is_first_row  (c_is_first_row),
        .is_last_row   (c_is_last_row),
        .is_last_col   (c_is_last_col),
        .is_last_chn   (c_is_last_chn),
        .fm_rd_en      (fm_rd_en),
        .fm_rd_addr    (fm_rd_addr),
        .row_rd_en     (row_rd_en),
        .row_rd_addr   (row_rd_addr),
        .row_wr_addr   (row_wr_addr),
        .beat_vld_d    (beat_vld_d),
        .first_row_d   (first_row_d),
        .last_row_d    (last_row_d),
        .row_advance_d (row_advance_d)
    );

    row_window u_window (
        .clk           (clk),
        .rstn          (rstn),
        .scan_start    (scan_start),
        .pf_wr_vld     (pf_wr_vld),
        .pf_wr_addr    (pf_wr_addr),
        .row_rd_en     (row_rd_en),
        .row_rd_addr   (row_rd_addr),
        .row_wr_addr   (row_wr_addr),
        .beat_vld_d    (beat_vld_d),
        .first_row_d   (first_row_d),
        .last_row_d    (last_row_d),
        .row_advance_d (row_advance_d),
        .fm_rd_data    (fm_rd_data),
        .ib_data0      (ib_data0),
        .ib_data1      (ib_data1),
        .ib_data2      (ib_data2)
    );

endmodule

// ==== tb_line_buffer.sv ====
`timescale 1ns/10ps
`include "line_buffer_params.svh"

module tb_line_buffer;

    import lb_data_pkg::*;

    // --------------------
    // DUT signals
    // --------------------
    logic                  clk;
    logic                  rstn;
    chn_t                  q_channel;
    stride_t               q_row_stride;
    logic                  q_load_ifm;
    logic [`LB_AXI_DW-1:0] read_data;
    logic                  read_data_vld;
    logic                  c_ctrl_data_run;
    logic                  c_ctrl_csync_run;
    size_t                 c_row;
    size_t                 c_col;
    chn_t                  c_chn;
    logic                  c_is_first_row;
    logic                  c_is_last_row;
    logic                  c_is_last_col;
    logic                  c_is_last_chn;
    logic                  bm_csync_done;
    ifm_word_t             ib_data0;
    ifm_word_t             ib_data1;
    ifm_word_t             ib_data2;

    // image copy indexed like the feature-map RAM
    ifm_word_t   img [`LB_FM_DEPTH];
    int          g_width;
    int          g_height;
    int          g_chn;
    int          g_stride;
    logic [31:0] rng;
    // expected triples with the top bit set for a real beat
    logic [96:0] exp_q [$];
    logic [96:0] cmp_entry;
    int          beats_sent;
    int          beats_checked;

    line_buffer dut_i (
        .clk              (clk),
        .rstn             (rstn),
        .q_channel        (q_channel),
        .q_row_stride     (q_row_stride),
        .q_load_ifm       (q_load_ifm),
        .read_data        (read_data),
        .read_data_vld    (read_data_vld),
        .c_ctrl_data_run  (c_ctrl_data_run),
        .c_ctrl_csync_run (c_ctrl_csync_run),
        .c_row            (c_row),
        .c_col            (c_col),
        .c_chn            (c_chn),
        .c_is_first_row   (c_is_first_row),
        .c_is_last_row    (c_is_last_row),
        .c_is_last_col    (c_is_last_col),
        .c_is_last_chn    (c_is_last_chn),
        .bm_csync_done    (bm_csync_done),
        .ib_data0         (ib_data0),
        .ib_data1         (ib_data1),
        .ib_data2         (ib_data2)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // --------------------
    // helpers
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // above, current and below words of one beat with zero rows past the edges
    function automatic logic [95:0] ref_window(input int r, input int c, input int k);
        int        addr;
        ifm_word_t abv;
        ifm_word_t cur;
        ifm_word_t bel;
        addr = r * g_stride + c * g_chn + k;
        abv  = '0;
        bel  = '0;
        cur  = img[addr];
        if (r > 0) begin
            abv = img[addr - g_stride];
        end
        if (r < g_height - 1) begin
            bel = img[addr + g_stride];
        end
        return {abv, cur, bel};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("STATUS: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run("stopping at the first mismatch");
        end
    endtask

    task automatic set_geometry(input int w, input int h, input int ch);
        g_width      = w;
        g_height     = h;
        g_chn        = ch;
        g_stride     = w * ch;
        q_channel    = chn_t'(ch);
        q_row_stride = stride_t'(w * ch);
    endtask

    task automatic fill_image();
        for (int a = 0; a < g_stride * g_height; a++) begin
            rng    = xorshift32(rng);
            img[a] = rng;
        end
    endtask

    // stream the image with random holes in the valid
    task automatic load_image();
        int gap;
        q_load_ifm = 1'b1;
        for (int a = 0; a < g_stride * g_height; a++) begin
            rng = xorshift32(rng);
            gap = int'(rng[1:0]);
            read_data_vld = 1'b0;
            repeat (gap) @(negedge clk);
            read_data_vld = 1'b1;
            read_data     = img[a];
            @(negedge clk);
        end
        read_data_vld = 1'b0;
        read_data     = '0;
        q_load_ifm    = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    task automatic wait_csync_done(input int limit);
        int n;
        n = 0;
        while (bm_csync_done !== 1'b1) begin
            if (n >= limit) begin
                abort_run("timeout waiting for bm_csync_done to rise");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // row 0 copy then csync release
    task automatic run_prefill();
        c_ctrl_csync_run = 1'b1;
        @(negedge clk);
        wait_csync_done(g_stride + 20);
        c_ctrl_csync_run = 1'b0;
        @(negedge clk);
        check("bm_csync_done", 32'(bm_csync_done), 32'h0);
    endtask

    // raster order with channel innermost
    task automatic scan_frame(input bit gaps);
        for (int r = 0; r < g_height; r++) begin
            for (int c = 0; c < g_width; c++) begin
                for (int k = 0; k < g_chn; k++) begin
                    // idle holes only inside a row
                    if (gaps && (c != 0 || k != 0)) begin
                        rng = xorshift32(rng);
                        if (rng[2:0] < 3'd2) begin
                            c_ctrl_data_run = 1'b0;
                            repeat (int'(rng[4:3]) + 1) @(negedge clk);
                        end
                    end
                    c_ctrl_data_run = 1'b1;
                    c_row           = size_t'(r);
                    c_col           = size_t'(c);
                    c_chn           = chn_t'(k);
                    c_is_first_row  = (r == 0);
                    c_is_last_row   = (r == g_height - 1);
                    c_is_last_col   = (c == g_width - 1);
                    c_is_last_chn   = (k == g_chn - 1);
                    beats_sent++;
                    @(negedge clk);
                end
            end
        end
        c_ctrl_data_run = 1'b0;
        c_is_first_row  = 1'b0;
        c_is_last_row   = 1'b0;
        c_is_last_col   = 1'b0;
        c_is_last_chn   = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic drain_checks(input int limit);
        int n;
        n = 0;
        while (beats_checked != beats_sent) begin
            if (n >= limit) begin
                abort_run("timeout with window words still unchecked");
            end
            @(negedge clk);
            n++;
        end
    endtask

    // --------------------
    // scoreboard
    // --------------------
    // beat inputs are sampled where the DUT samples them
    always @(posedge clk) begin
        if (rstn) begin
            if (c_ctrl_data_run) begin
                exp_q.push_back({1'b1, ref_window(int'(c_row), int'(c_col), int'(c_chn))});
            end else begin
                exp_q.push_back(97'd0);
            end
        end
    end

    // words trail the driven beat by three edges so the oldest of three entries is due
    always @(negedge clk) begin
        if (exp_q.size() >= 3) begin
            cmp_entry = exp_q.pop_front();
            check("ib_data0", ib_data0, cmp_entry[95:64]);
            check("ib_data1", ib_data1, cmp_entry[63:32]);
            check("ib_data2", ib_data2, cmp_entry[31:0]);
            if (cmp_entry[96]) begin
                beats_checked++;
            end
        end
    end

    // --------------------
    // stimulus
    // --------------------
    initial begin
        clk              = 1'b0;
        rstn             = 1'b0;
        q_channel        = '0;
        q_row_stride     = '0;
        q_load_ifm       = 1'b0;
        read_data        = '0;
        read_data_vld    = 1'b0;
        c_ctrl_data_run  = 1'b0;
        c_ctrl_csync_run = 1'b0;
        c_row            = '0;
        c_col            = '0;
        c_chn            = '0;
        c_is_first_row   = 1'b0;
        c_is_last_row    = 1'b0;
        c_is_last_col    = 1'b0;
        c_is_last_chn    = 1'b0;
        rng              = 32'hda609541;
        beats_sent       = 0;
        beats_checked    = 0;

        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);

        // quiet after reset
        check("bm_csync_done", 32'(bm_csync_done), 32'h0);
        check("ib_data0", ib_data0, 32'h0);
        check("ib_data1", ib_data1, 32'h0);
        check("ib_data2", ib_data2, 32'h0);

        // frame 1 is 6 wide and 5 high with 3 channels
        set_geometry(6, 5, 3);
        fill_image();
        load_image();
        run_prefill();
        scan_frame(1'b0);
        // same image again with holes inside rows
        run_prefill();
        scan_frame(1'b1);

        // frame 2 with new geometry and data
        set_geometry(4, 7, 2);
        fill_image();
        load_image();
        run_prefill();
        scan_frame(1'b1);

        drain_checks(20);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== line_buffer.f ====
+incdir+.
lb_data_pkg.sv
lb_ctrl_pkg.sv
dpram.sv
ifm_loader.sv
prefill_ctrl.sv
window_addr_gen.sv
row_window.sv
line_buffer.sv
tb_line_buffer.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_line_buffer
FILELIST  = line_buffer.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
